// File: pcie_outbound_write.f
+incdir+rtl
rtl/pcie_ow_pkg.sv
rtl/ow_fifo.sv
rtl/ow_beat_splitter.sv
rtl/ow_tlp_merger.sv
rtl/ow_resp_tracker.sv
rtl/pcie_outbound_write.sv
verification/pcie_ow_assertions.sv
verification/pcie_ow_tb.sv

// File: rtl/ow_beat_splitter.sv
`timescale 1ns/10ps
`include "pcie_ow_macros.svh"

module ow_beat_splitter (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  aw_valid,
    output logic                  aw_ready,
    input  pcie_ow_pkg::aw_cmd_t  aw,
    input  logic                  w_valid,
    output logic                  w_ready,
    input  pcie_ow_pkg::w_beat_t  w,
    output logic                  cmd_valid,
    input  logic                  cmd_ready,
    output pcie_ow_pkg::dw_cmd_t  cmd,
    output logic                  pay_push,
    output pcie_ow_pkg::pay_word_t pay_data,
    input  logic                  pay_full,
    input  logic                  b_done
);

    import pcie_ow_pkg::*;

    localparam int DWA_W = `OW_ADDR_W - 2;
    localparam int MOT_W = $clog2(`OW_MAX_OUTSTANDING + 1);

    aw_cmd_t              hold;
    logic                 hold_valid;
    logic                 hold_valid_n;
    logic                 active;
    logic [`OW_LEN_W-1:0] rem;
    logic [DWA_W-1:0]     next_addr;
    logic [MOT_W-1:0]     mot_cnt;
    logic [MOT_W-1:0]     mot_cnt_n;
    logic [DWA_W-1:0]     beat_addr;
    logic [`OW_LEN_W-1:0] beat_rem;
    logic                 beat_last;
    logic                 beat_cont;
    logic                 aw_take;
    logic                 update;

    // First beat of a burst comes from the held AW
    always_comb begin
        if (active) begin
            beat_addr = next_addr;
            beat_rem  = rem;
        end else begin
            beat_addr = hold.addr[`OW_ADDR_W-1:2];
            beat_rem  = hold.len;
        end
    end

    assign beat_last = (beat_rem == '0);
    // Follows the previous dword and does not open a 4 KB page
    assign beat_cont = (beat_addr == next_addr) && (beat_addr[9:0] != 10'd0);

    assign w_ready  = (active || hold_valid) && (!cmd_valid || cmd_ready) && !pay_full;
    assign update   = w_valid && w_ready;
    assign aw_take  = aw_valid && aw_ready;
    assign pay_push = update;

    always_comb begin
        pay_data.data = w.data;
        pay_data.last = beat_last;
    end

    assign hold_valid_n = aw_take || (hold_valid && !(update && !active));
    assign mot_cnt_n    = mot_cnt + MOT_W'(aw_take) - MOT_W'(b_done);

    always_ff @(posedge clk) begin
        if (rst) begin
            hold_valid <= 1'b0;
            active     <= 1'b0;
            mot_cnt    <= '0;
            aw_ready   <= 1'b0;
            cmd_valid  <= 1'b0;
        end else begin
            hold_valid <= hold_valid_n;
            mot_cnt    <= mot_cnt_n;
            aw_ready   <= !hold_valid_n && (mot_cnt_n < MOT_W'(`OW_MAX_OUTSTANDING));
            if (update) begin
                active <= !beat_last;
            end
            if (update) begin
                cmd_valid <= 1'b1;
            end else if (cmd_ready) begin
                cmd_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_take) begin
            hold <= aw;
        end
        if (update) begin
            rem           <= beat_rem - 1'b1;
            next_addr     <= beat_addr + 1'b1;
            cmd.dw_addr   <= beat_addr;
            cmd.strb      <= w.strb;
            cmd.addr_cont <= beat_cont;
            cmd.cmd_last  <= beat_last;
        end
    end

endmodule

// File: rtl/ow_fifo.sv
`timescale 1ns/10ps

module ow_fifo #(
    parameter type T     = logic [31:0],
    parameter int  DEPTH = 16
) (
    input  logic clk,
    input  logic rst,
    input  logic push,
    input  T     push_data,
    output logic full,
    input  logic out_ready,
    output logic out_valid,
    output T     out_data
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    T              mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          wr;
    logic          pop;

    assign full = (count == CW'(DEPTH));
    assign wr   = push && !full;
    // Refill the output register when it is free or being taken
    assign pop  = (count != '0) && (!out_valid || out_ready);

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_ptr] <= push_data;
        end
        if (pop) begin
            out_data <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            out_valid <= 1'b0;
        end else begin
            if (wr) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CW'(wr) - CW'(pop);
            if (pop) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

endmodule

// File: rtl/ow_resp_tracker.sv
`timescale 1ns/10ps
`include "pcie_ow_macros.svh"

module ow_resp_tracker (
    input  logic       clk,
    input  logic       rst,
    input  logic       burst_done,
    input  logic       b_ready,
    output logic       b_valid,
    output logic [1:0] b_resp,
    output logic       b_done
);

    localparam int CW = $clog2(`OW_MAX_OUTSTANDING + 1);

    logic [CW-1:0] pending;

    assign b_done = b_valid && b_ready;
    // OKAY only
    assign b_resp = 2'b00;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
            b_valid <= 1'b0;
        end else begin
            case ({burst_done, b_done})
                2'b10: begin
                    pending <= pending + 1'b1;
                    b_valid <= 1'b1;
                end
                2'b01: begin
                    pending <= pending - 1'b1;
                    b_valid <= (pending != CW'(1));
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// File: rtl/ow_tlp_merger.sv
`timescale 1ns/10ps
`include "pcie_ow_macros.svh"

module ow_tlp_merger (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cmd_valid,
    output logic                  cmd_ready,
    input  pcie_ow_pkg::dw_cmd_t  cmd,
    input  logic [2:0]            max_payload_size,
    input  logic                  hdr_full,
    output logic                  hdr_push,
    output pcie_ow_pkg::tlp_hdr_t hdr
);

    import pcie_ow_pkg::*;

    localparam int MAX_DW = `OW_MAX_SIZE / 4;

    logic        tlp_valid;
    logic        tlp_cmd_last;
    logic [10:0] mps_dw;
    logic [10:0] eff_dw;
    logic        len_one;
    logic        at_max;
    logic        contig;
    logic        sparse_qw;
    logic        can_merge;
    logic        tlp_update;

    // Enables packed against the upper end of the dword
    function automatic logic high_contig(input logic [3:0] be);
        return be inside {4'hF, 4'hE, 4'hC, 4'h8};
    endfunction

    function automatic logic low_contig(input logic [3:0] be);
        return be inside {4'hF, 4'h7, 4'h3, 4'h1};
    endfunction

    // 128 bytes << max_payload_size, capped at 4 KB, then at the build limit
    always_comb begin
        if (max_payload_size > 3'd5) begin
            mps_dw = 11'd1024;
        end else begin
            mps_dw = 11'd32 << max_payload_size;
        end
        if (mps_dw < 11'(MAX_DW)) begin
            eff_dw = mps_dw;
        end else begin
            eff_dw = 11'(MAX_DW);
        end
    end

    assign len_one = (hdr.len == 10'd1);
    assign at_max  = ({1'b0, hdr.len} >= eff_dw);

    assign contig = high_contig(hdr.be_first) && low_contig(cmd.strb) &&
                    (len_one || hdr.be_last == 4'hF);

    // QW aligned pair may carry sparse strobes
    assign sparse_qw = len_one && !hdr.addr[0] && (hdr.be_first != 4'h0) &&
                       (cmd.strb != 4'h0);

    assign can_merge  = cmd.addr_cont && !at_max && (contig || sparse_qw);
    assign cmd_ready  = !tlp_valid || can_merge;
    assign tlp_update = cmd_valid && cmd_ready;

    // Close on a failed merge, or on a pause right after a burst end
    assign hdr_push = tlp_valid && !hdr_full && (cmd_valid ? !can_merge : tlp_cmd_last);

    always_ff @(posedge clk) begin
        if (rst) begin
            tlp_valid <= 1'b0;
        end else if (tlp_update) begin
            tlp_valid <= 1'b1;
        end else if (hdr_push) begin
            tlp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (tlp_update) begin
            tlp_cmd_last <= cmd.cmd_last;
            if (!tlp_valid) begin
                hdr.addr     <= cmd.dw_addr;
                hdr.len      <= 10'd1;
                hdr.be_first <= cmd.strb;
                hdr.be_last  <= 4'h0;
            end else begin
                hdr.len     <= hdr.len + 10'd1;
                hdr.be_last <= cmd.strb;
            end
        end
    end

endmodule

// File: rtl/pcie_outbound_write.sv
`timescale 1ns/10ps
`include "pcie_ow_macros.svh"

module pcie_outbound_write (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   aw_valid,
    output logic                   aw_ready,
    input  pcie_ow_pkg::aw_cmd_t   aw,
    input  logic                   w_valid,
    output logic                   w_ready,
    input  pcie_ow_pkg::w_beat_t   w,
    output logic                   b_valid,
    input  logic                   b_ready,
    output logic [1:0]             b_resp,
    input  logic [2:0]             max_payload_size,
    output logic                   tlp_h_valid,
    input  logic                   tlp_h_ready,
    output pcie_ow_pkg::tlp_hdr_t  tlp_h,
    output logic                   tlp_d_valid,
    input  logic                   tlp_d_ready,
    output pcie_ow_pkg::pay_word_t tlp_d
);

    import pcie_ow_pkg::*;

    logic      cmd_valid;
    logic      cmd_ready;
    dw_cmd_t   cmd;
    logic      pay_push;
    pay_word_t pay_data;
    logic      pay_full;
    logic      hdr_push;
    tlp_hdr_t  hdr;
    logic      hdr_full;
    logic      burst_done;
    logic      b_done;

    // A burst finishes when its last dword leaves
    assign burst_done = tlp_d_valid && tlp_d_ready && tlp_d.last;

    ow_beat_splitter u_beat_splitter (
        .clk       (clk),
        .rst       (rst),
        .aw_valid  (aw_valid),
        .aw_ready  (aw_ready),
        .aw        (aw),
        .w_valid   (w_valid),
        .w_ready   (w_ready),
        .w         (w),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd       (cmd),
        .pay_push  (pay_push),
        .pay_data  (pay_data),
        .pay_full  (pay_full),
        .b_done    (b_done)
    );

    ow_fifo #(
        .T     (pay_word_t),
        .DEPTH (`OW_PAYLOAD_DEPTH)
    ) u_pay_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (pay_push),
        .push_data (pay_data),
        .full      (pay_full),
        .out_ready (tlp_d_ready),
        .out_valid (tlp_d_valid),
        .out_data  (tlp_d)
    );

    ow_tlp_merger u_tlp_merger (
        .clk              (clk),
        .rst              (rst),
        .cmd_valid        (cmd_valid),
        .cmd_ready        (cmd_ready),
        .cmd              (cmd),
        .max_payload_size (max_payload_size),
        .hdr_full         (hdr_full),
        .hdr_push         (hdr_push),
        .hdr              (hdr)
    );

    ow_fifo #(
        .T     (tlp_hdr_t),
        .DEPTH (`OW_HDR_DEPTH)
    ) u_hdr_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (hdr_push),
        .push_data (hdr),
        .full      (hdr_full),
        .out_ready (tlp_h_ready),
        .out_valid (tlp_h_valid),
        .out_data  (tlp_h)
    );

    ow_resp_tracker u_resp_tracker (
        .clk        (clk),
        .rst        (rst),
        .burst_done (burst_done),
        .b_ready    (b_ready),
        .b_valid    (b_valid),
        .b_resp     (b_resp),
        .b_done     (b_done)
    );

endmodule

// File: rtl/pcie_ow_macros.svh
`ifndef PCIE_OW_MACROS_SVH
`define PCIE_OW_MACROS_SVH

// Byte address and AXI length widths
`define OW_ADDR_W           32
`define OW_LEN_W            4

// Largest TLP payload in bytes
`define OW_MAX_SIZE         256

`define OW_PAYLOAD_DEPTH    (`OW_MAX_SIZE/4)
`define OW_HDR_DEPTH        16

`define OW_MAX_OUTSTANDING  15

`endif

// File: rtl/pcie_ow_pkg.sv
`include "pcie_ow_macros.svh"

package pcie_ow_pkg;

    // AXI write command
    typedef struct packed {
        logic [`OW_ADDR_W-1:0] addr;
        logic [`OW_LEN_W-1:0]  len;
    } aw_cmd_t;

    // AXI write data beat
    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } w_beat_t;

    // Payload dword as buffered and sent
    typedef struct packed {
        logic [31:0] data;
        logic        last;
    } pay_word_t;

    typedef struct packed {
        logic [`OW_ADDR_W-3:0] dw_addr;
        logic [3:0]            strb;
        logic                  addr_cont;
        logic                  cmd_last;
    } dw_cmd_t;

    // Memory write header, len in dwords
    typedef struct packed {
        logic [`OW_ADDR_W-3:0] addr;
        logic [9:0]            len;
        logic [3:0]            be_first;
        logic [3:0]            be_last;
    } tlp_hdr_t;

endpackage

// File: verification/pcie_ow_assertions.sv
`timescale 1ns/10ps

module pcie_ow_assertions (
    input logic                   clk,
    input logic                   rst,
    input logic                   tlp_h_valid,
    input logic                   tlp_h_ready,
    input pcie_ow_pkg::tlp_hdr_t  tlp_h,
    input logic                   tlp_d_valid,
    input logic                   tlp_d_ready,
    input pcie_ow_pkg::pay_word_t tlp_d,
    input logic                   b_valid,
    input logic                   b_ready,
    input logic [1:0]             b_resp
);

    // Failure tally
    int fail_cnt = 0;

    // Valid and data hold until taken
    a_hdr_hold: assert property (@(posedge clk) disable iff (rst)
        tlp_h_valid && !tlp_h_ready |=> tlp_h_valid && $stable(tlp_h))
        else begin
            $error("tlp_h dropped or changed before ready");
            fail_cnt++;
        end

    a_pay_hold: assert property (@(posedge clk) disable iff (rst)
        tlp_d_valid && !tlp_d_ready |=> tlp_d_valid && $stable(tlp_d))
        else begin
            $error("tlp_d dropped or changed before ready");
            fail_cnt++;
        end

    a_b_hold: assert property (@(posedge clk) disable iff (rst)
        b_valid && !b_ready |=> b_valid && $stable(b_resp))
        else begin
            $error("b_valid dropped before ready");
            fail_cnt++;
        end

    a_b_okay: assert property (@(posedge clk) disable iff (rst) b_resp == 2'b00)
        else begin
            $error("b_resp not OKAY");
            fail_cnt++;
        end

    a_reset_quiet: assert property (@(posedge clk)
        rst && $past(rst) |-> !tlp_h_valid && !tlp_d_valid && !b_valid)
        else begin
            $error("valid output high during reset");
            fail_cnt++;
        end

endmodule

bind pcie_outbound_write pcie_ow_assertions u_assertions (.*);

// File: verification/pcie_ow_tb.sv
`timescale 1ns/10ps
`include "pcie_ow_macros.svh"

module pcie_ow_tb;

    import pcie_ow_pkg::*;

    localparam int N_ENT     = 42;
    localparam int LIMIT_CYC = N_ENT * 200 + 2000;
    localparam logic [1:0] RESP_OKAY = 2'b00;

    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  len;
        logic [63:0] strb;
        logic [2:0]  mps;
        logic        gap;
    } entry_t;

    logic clk = 1'b0;
    logic rst;
    logic aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
    logic tlp_h_valid, tlp_h_ready, tlp_d_valid, tlp_d_ready;
    logic [1:0] b_resp;
    logic [2:0] max_payload_size;
    aw_cmd_t aw;
    w_beat_t w;
    tlp_hdr_t tlp_h;
    pay_word_t tlp_d;

    entry_t tbl[$];
    logic [31:0] beat_data [N_ENT*16];
    tlp_hdr_t exp_h[$];
    pay_word_t exp_p[$];
    logic [31:0] lcg_state = 32'd55;
    int hdr_err = 0, pay_err = 0, resp_err = 0;
    int b_cnt = 0, last_cnt = 0;
    logic bp_on = 1'b0, b_hold = 1'b0, b_pulse = 1'b0;

    always #4 clk = ~clk;

    pcie_outbound_write u_pcie_outbound_write (
        .clk(clk), .rst(rst),
        .aw_valid(aw_valid), .aw_ready(aw_ready), .aw(aw),
        .w_valid(w_valid), .w_ready(w_ready), .w(w),
        .b_valid(b_valid), .b_ready(b_ready), .b_resp(b_resp),
        .max_payload_size(max_payload_size),
        .tlp_h_valid(tlp_h_valid), .tlp_h_ready(tlp_h_ready), .tlp_h(tlp_h),
        .tlp_d_valid(tlp_d_valid), .tlp_d_ready(tlp_d_ready), .tlp_d(tlp_d)
    );

    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Ready high three times in four
    function logic ready_draw();
        logic [31:0] r;
        r = lcg_next();
        return |r[17:16];
    endfunction

    // Run of set bits reaching bit 3, or starting at bit 0
    function automatic logic is_high_run(input logic [3:0] be);
        logic hit;
        hit = 1'b0;
        for (int k = 0; k < 4; k++) hit |= (be == 4'((4'hF << k)));
        return hit;
    endfunction

    function automatic logic is_low_run(input logic [3:0] be);
        logic hit;
        hit = 1'b0;
        for (int k = 0; k < 4; k++) hit |= (be == (4'hF >> k));
        return hit;
    endfunction

    task automatic add_entry(input logic [31:0] a, input int len, input logic [63:0] s,
                             input int mps, input logic gap);
        entry_t e;
        e = '{a, 4'(len), s, 3'(mps), gap};
        for (int b = 0; b < 16; b++) beat_data[tbl.size()*16+b] = lcg_next();
        tbl.push_back(e);
    endtask

    task automatic build_table();
        add_entry(32'h1000, 7, '1, 0, 1);
        add_entry(32'h2000, 0, '1, 0, 1);
        add_entry(32'h3000, 3, '1, 0, 1);
        add_entry(32'h3010, 3, '1, 0, 0);
        add_entry(32'h3020, 3, '1, 0, 1);
        for (int i = 0; i < 6; i++) add_entry(32'h4000 + i*64, 15, '1, 0, i == 0);
        for (int i = 0; i < 6; i++) add_entry(32'h5000 + i*64, 15, '1, 1, i == 0);
        add_entry(32'h5FF8, 7, '1, 1, 1);
        add_entry(32'h7000, 3, 64'hF7FF, 0, 1);
        add_entry(32'h7100, 1, 64'hA5, 0, 1);
        add_entry(32'h7204, 1, 64'hA5, 0, 1);
        // Random back-pressure group, headers close at burst ends
        for (int i = 0; i < 6; i++) add_entry(32'h8000 + i*256, 3 + 2*i, '1, 0, 1);
        for (int i = 0; i < 15; i++) add_entry(32'h9000 + i*64, 0, '1, 0, 1);
    endtask

    task automatic build_model();
        tlp_hdr_t cur;
        pay_word_t pw;
        logic open, cont, contig, sparse;
        logic [29:0] dw, prev_next;
        logic [3:0] s;
        int eff;
        open = 1'b0;
        prev_next = '0;
        foreach (tbl[e]) begin
            dw = tbl[e].addr[31:2];
            if (tbl[e].gap && open) begin
                exp_h.push_back(cur);
                open = 1'b0;
            end
            eff = ((32 << tbl[e].mps) < `OW_MAX_SIZE/4) ? (32 << tbl[e].mps) : `OW_MAX_SIZE/4;
            for (int b = 0; b <= tbl[e].len; b++) begin
                s = tbl[e].strb[b*4 +: 4];
                cont = (dw == prev_next) && (dw[9:0] != 10'd0);
                contig = is_high_run(cur.be_first) && is_low_run(s) &&
                         (cur.len == 10'd1 || cur.be_last == 4'hF);
                sparse = cur.len == 10'd1 && !cur.addr[0] && cur.be_first != 0 && s != 0;
                if (open && cont && cur.len < eff && (contig || sparse)) begin
                    cur.len = cur.len + 10'd1;
                    cur.be_last = s;
                end else begin
                    if (open) exp_h.push_back(cur);
                    cur = '{dw, 10'd1, s, 4'h0};
                    open = 1'b1;
                end
                pw.data = beat_data[e*16+b];
                pw.last = (b == tbl[e].len);
                exp_p.push_back(pw);
                prev_next = dw + 1'b1;
                dw = dw + 1'b1;
            end
        end
        if (open) exp_h.push_back(cur);
    endtask

    task automatic check_hdr(input tlp_hdr_t got, input tlp_hdr_t exp);
        if (got !== exp) begin
            hdr_err++;
            $display("[FAIL] %0t tlp_h got=%h exp=%h", $time, got, exp);
        end
    endtask

    task automatic check_pay(input pay_word_t got, input pay_word_t exp);
        if (got !== exp) begin
            pay_err++;
            $display("[FAIL] %0t tlp_d got=%h exp=%h", $time, got, exp);
        end
    endtask

    task automatic check_resp(input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            resp_err++;
            $display("[FAIL] %0t b_resp got=%h exp=%h", $time, got, exp);
        end
    endtask

    task automatic drive_aw(input int lo, input int hi);
        for (int e = lo; e <= hi; e++) begin
            aw_valid = 1'b1;
            aw = '{tbl[e].addr, tbl[e].len};
            @(posedge clk);
            while (!aw_ready) @(posedge clk);
            #1 aw_valid = 1'b0;
        end
    endtask

    task automatic drive_w(input int lo, input int hi);
        for (int e = lo; e <= hi; e++) begin
            if (tbl[e].gap) begin
                w_valid = 1'b0;
                repeat (4) @(posedge clk);
                #1;
            end
            max_payload_size = tbl[e].mps;
            for (int b = 0; b <= tbl[e].len; b++) begin
                w_valid = 1'b1;
                w = '{beat_data[e*16+b], tbl[e].strb[b*4 +: 4], b == tbl[e].len};
                @(posedge clk);
                while (!w_ready) @(posedge clk);
                #1;
            end
        end
        w_valid = 1'b0;
    endtask

    task automatic run_range(input int lo, input int hi);
        fork
            drive_aw(lo, hi);
            drive_w(lo, hi);
        join
    endtask

    // Ready drivers, random when back-pressure is on
    always @(posedge clk) begin
        #1;
        tlp_h_ready = bp_on ? ready_draw() : 1'b1;
        tlp_d_ready = bp_on ? ready_draw() : 1'b1;
        if (b_hold) b_ready = b_pulse;
        else b_ready = bp_on ? ready_draw() : 1'b1;
    end

    always @(posedge clk) begin
        if (!rst) begin
            if (tlp_h_valid && tlp_h_ready) begin
                if (exp_h.size() == 0) begin
                    hdr_err++;
                    $display("%0t unexpected header with none left in the model", $time);
                end else check_hdr(tlp_h, exp_h.pop_front());
            end
            if (tlp_d_valid && tlp_d_ready) begin
                if (exp_p.size() == 0) begin
                    pay_err++;
                    $display("%0t unexpected payload dword with none left", $time);
                end else check_pay(tlp_d, exp_p.pop_front());
                if (tlp_d.last) last_cnt++;
            end
            if (b_valid && b_ready) begin
                b_cnt++;
                check_resp(b_resp, RESP_OKAY);
            end
            if (b_cnt > last_cnt) begin
                resp_err++;
                $display("%0t write response before its burst finished", $time);
            end
        end
    end

    initial begin
        repeat (LIMIT_CYC) @(posedge clk);
        $display("Timeout after %0d cycles, traffic did not drain", LIMIT_CYC);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        int n;
        int asrt_err;
        rst = 1'b1;
        aw_valid = 1'b0;
        w_valid = 1'b0;
        aw = '0;
        w = '0;
        b_ready = 1'b1;
        tlp_h_ready = 1'b1;
        tlp_d_ready = 1'b1;
        max_payload_size = 3'd0;
        build_table();
        build_model();
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
        run_range(0, 20);
        bp_on = 1'b1;
        run_range(21, 26);
        while (b_cnt != 27 || last_cnt != 27) @(posedge clk);
        bp_on = 1'b0;
        b_hold = 1'b1;
        #1;
        run_range(27, N_ENT - 1);
        while (last_cnt != N_ENT) @(posedge clk);
        repeat (3) @(posedge clk);
        #1;
        if (aw_ready !== 1'b0) begin
            resp_err++;
            $display("%0t aw_ready still high with the outstanding limit reached", $time);
        end
        // One B handshake
        @(posedge clk);
        b_pulse = 1'b1;
        @(posedge clk);
        while (!(b_valid && b_ready)) @(posedge clk);
        b_pulse = 1'b0;
        n = 0;
        while (!aw_ready && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (!aw_ready) begin
            resp_err++;
            $display("%0t aw_ready did not return after a write response", $time);
        end
        b_hold = 1'b0;
        while (exp_h.size() != 0 || exp_p.size() != 0 || b_cnt < N_ENT) @(posedge clk);
        repeat (10) @(posedge clk);
        if (b_cnt != N_ENT) begin
            resp_err++;
            $display("Response count %0d does not match %0d bursts", b_cnt, N_ENT);
        end
        asrt_err = u_pcie_outbound_write.u_assertions.fail_cnt;
        $display("errors: hdr=%0d pay=%0d resp=%0d assert=%0d",
                 hdr_err, pay_err, resp_err, asrt_err);
        if (hdr_err + pay_err + resp_err + asrt_err == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
